// ==== nes_dma.f ====
source/nes_dma_pkg.sv
source/cpu_clock_enable.sv
source/dmc_dma.sv
source/sprite_dma.sv
source/dma_bus_mux.sv
source/nes_dma_top.sv
tests/tb_clock.sv
tests/nes_dma_chk.sv
tests/nes_dma_tb.sv

// ==== source/cpu_clock_enable.sv ====
// --------------------
// CPU clock enable from the master clock, one pulse per CPU_DIVIDE clocks
// odd_cycle is the phase of the CPU cycle that ends at the pulse
// First CPU cycle after reset is even
// --------------------
`timescale 1ns/100ps

module cpu_clock_enable #(
	parameter int CPU_DIVIDE = nes_dma_pkg::CPU_DIVIDE_NTSC
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic odd_cycle
);

	localparam int CNT_W = (CPU_DIVIDE > 1) ? $clog2(CPU_DIVIDE) : 1;
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CPU_DIVIDE - 1);

	logic [CNT_W-1:0] div_count;   // Master clocks into the current CPU cycle

	assign cpu_ce = (div_count == LAST_COUNT);   // Last master clock of the CPU cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			div_count <= '0;
			odd_cycle <= 1'b0;
		end else begin
			if (cpu_ce) begin
				div_count <= '0;          // Wrap
				odd_cycle <= ~odd_cycle;  // Phase flips with every CPU cycle
			end else begin
				div_count <= div_count + 1'b1;
			end
		end
	end

endmodule

// ==== source/dma_bus_mux.sv ====
// --------------------
// Memory bus owner select, sprite trigger decode and CPU pause
// Sample fetch wins over the sprite copy, the CPU bus is the fallback
// Combinational, inputs are taken at the cpu_ce of the cycle
// --------------------
`timescale 1ns/100ps

module dma_bus_mux (
	input  nes_dma_pkg::cpu_bus_t  cpu_bus,
	input  logic                   odd_cycle,
	input  logic                   dmc_ack,
	input  nes_dma_pkg::cpu_addr_t dmc_addr,
	input  logic                   dmc_req,
	input  logic                   sprite_busy,
	input  logic                   sprite_owns_bus,
	input  nes_dma_pkg::cpu_addr_t sprite_addr,
	input  nes_dma_pkg::data_t     sprite_data,
	input  logic                   cpu_ce,
	output nes_dma_pkg::mem_bus_t  mem_bus,
	output logic                   sprite_start,
	output nes_dma_pkg::page_t     sprite_page,
	output logic                   pause_cpu
);

	always_comb begin
		if (dmc_ack) begin
			// Sample fetch is always a read
			mem_bus.addr  = dmc_addr;
			mem_bus.wdata = sprite_data;
			mem_bus.rd    = 1'b1;
			mem_bus.wr    = 1'b0;
		end else if (sprite_owns_bus) begin
			mem_bus.addr  = sprite_addr;
			mem_bus.wdata = sprite_data;
			mem_bus.rd    = !odd_cycle;   // Even cycle reads the page
			mem_bus.wr    = odd_cycle;    // Odd cycle writes the sprite register
		end else begin
			mem_bus.addr  = cpu_bus.addr;
			mem_bus.wdata = cpu_bus.wdata;
			mem_bus.rd    = cpu_bus.rnw;
			mem_bus.wr    = !cpu_bus.rnw;
		end
	end

	// Page write ends its cycle at cpu_ce
	// A held write during a running copy does not restart it
	assign sprite_start = cpu_ce && mem_bus.wr && !sprite_busy
		&& (mem_bus.addr == nes_dma_pkg::SPRITE_DMA_REG);
	assign sprite_page  = mem_bus.wdata;   // Written byte is the page number

	// CPU waits while a copy runs or a sample fetch is requested
	assign pause_cpu = sprite_busy || dmc_req;

endmodule

// ==== source/dmc_dma.sv ====
// --------------------
// Sample fetch slot for the audio channel
// Requester holds dmc_req and its address until dmc_ack at a cpu_ce
// Arms only on an even read cycle, fetch lands two CPU cycles later
// --------------------
`timescale 1ns/100ps

module dmc_dma (
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic odd_cycle,
	input  logic cpu_reading,   // CPU bus is in a read cycle
	input  logic dmc_req,
	output logic dmc_ack
);

	nes_dma_pkg::dmc_state_t dmc_state;

	// Fetch runs on the even cycle after arming, so it stays on the read phase
	assign dmc_ack = (dmc_state == nes_dma_pkg::dmc_pending) && !odd_cycle;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= nes_dma_pkg::dmc_idle;
		end else if (cpu_ce) begin
			case (dmc_state)
				nes_dma_pkg::dmc_idle: begin
					// Only a CPU read cycle can be stolen
					if (dmc_req && cpu_reading && !odd_cycle)
						dmc_state <= nes_dma_pkg::dmc_pending;
				end
				nes_dma_pkg::dmc_pending: begin
					if (!odd_cycle)
						dmc_state <= nes_dma_pkg::dmc_idle;  // Fetch done at this cpu_ce
				end
				default: dmc_state <= nes_dma_pkg::dmc_idle;
			endcase
		end
	end

endmodule

// ==== source/nes_dma_pkg.sv ====
// --------------------
// Shared bus types, FSM encodings and fixed register addresses
// Address map follows the console CPU side, no mirroring is decoded
// --------------------
package nes_dma_pkg;

	typedef logic [15:0] cpu_addr_t;   // CPU address
	typedef logic [7:0]  data_t;       // One data byte
	typedef logic [7:0]  page_t;       // High address byte of a sprite page

	// Outgoing CPU bus, no handshake besides the pause
	typedef struct packed {
		cpu_addr_t addr;
		data_t     wdata;
		logic      rnw;        // 1 = read, 0 = write
	} cpu_bus_t;

	// Bus leaving the block toward memory and registers
	typedef struct packed {
		cpu_addr_t addr;
		data_t     wdata;
		logic      rd;
		logic      wr;
	} mem_bus_t;

	typedef enum logic [1:0] {
		sprite_idle,
		sprite_align,          // Waiting for an odd read cycle
		sprite_transfer        // Read on even, write on odd
	} sprite_state_t;

	typedef enum logic {
		dmc_idle,
		dmc_pending            // Armed, fetch on the next even cycle
	} dmc_state_t;

	localparam cpu_addr_t SPRITE_DMA_REG = 16'h4014;   // Page write starts the copy
	localparam cpu_addr_t OAM_DATA_REG   = 16'h2004;   // Sprite data target
	localparam int CPU_DIVIDE_NTSC = 12;               // PAL would be 16

endpackage

// ==== source/nes_dma_top.sv ====
// --------------------
// DMA block of the console CPU side
// CPU_DIVIDE is 12 for NTSC, 16 for PAL
// Memory must answer rdata within the same clk as mem_bus
// --------------------
`timescale 1ns/100ps

module nes_dma_top #(
	parameter int CPU_DIVIDE = nes_dma_pkg::CPU_DIVIDE_NTSC
) (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_dma_pkg::cpu_bus_t  cpu_bus,
	input  nes_dma_pkg::data_t     rdata,
	input  logic                   dmc_req,
	input  nes_dma_pkg::cpu_addr_t dmc_addr,
	output nes_dma_pkg::mem_bus_t  mem_bus,
	output logic                   dmc_ack,
	output logic                   pause_cpu,
	output logic                   cpu_ce,
	output logic                   odd_cycle
);

	logic                   sprite_start;
	nes_dma_pkg::page_t     sprite_page;
	logic                   sprite_busy;
	logic                   sprite_owns_bus;
	nes_dma_pkg::cpu_addr_t sprite_addr;
	nes_dma_pkg::data_t     sprite_data;

	cpu_clock_enable #(
		.CPU_DIVIDE (CPU_DIVIDE)
	) u_clock (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dmc_dma u_dmc (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.cpu_reading (cpu_bus.rnw),
		.dmc_req     (dmc_req),
		.dmc_ack     (dmc_ack)
	);

	sprite_dma u_sprite (
		.clk             (clk),
		.reset           (reset),
		.cpu_ce          (cpu_ce),
		.odd_cycle       (odd_cycle),
		.cpu_reading     (cpu_bus.rnw),
		.sprite_start    (sprite_start),
		.sprite_page     (sprite_page),
		.rdata           (rdata),
		.dmc_ack         (dmc_ack),
		.sprite_busy     (sprite_busy),
		.sprite_owns_bus (sprite_owns_bus),
		.sprite_addr     (sprite_addr),
		.sprite_data     (sprite_data)
	);

	dma_bus_mux u_mux (
		.cpu_bus         (cpu_bus),
		.odd_cycle       (odd_cycle),
		.dmc_ack         (dmc_ack),
		.dmc_addr        (dmc_addr),
		.dmc_req         (dmc_req),
		.sprite_busy     (sprite_busy),
		.sprite_owns_bus (sprite_owns_bus),
		.sprite_addr     (sprite_addr),
		.sprite_data     (sprite_data),
		.cpu_ce          (cpu_ce),
		.mem_bus         (mem_bus),
		.sprite_start    (sprite_start),
		.sprite_page     (sprite_page),
		.pause_cpu       (pause_cpu)
	);

endmodule

// ==== source/sprite_dma.sv ====
// --------------------
// 256-byte sprite copy, page xx00..xxFF to the sprite data register
// Reads on even CPU cycles, writes on odd ones
// A sample fetch steals an even slot and costs one extra idle odd cycle
// --------------------
`timescale 1ns/100ps

module sprite_dma (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  logic                   odd_cycle,
	input  logic                   cpu_reading,
	input  logic                   sprite_start,   // Pulse at the page write
	input  nes_dma_pkg::page_t     sprite_page,
	input  nes_dma_pkg::data_t     rdata,
	input  logic                   dmc_ack,        // Sample fetch takes this slot
	output logic                   sprite_busy,
	output logic                   sprite_owns_bus,
	output nes_dma_pkg::cpu_addr_t sprite_addr,
	output nes_dma_pkg::data_t     sprite_data
);

	nes_dma_pkg::sprite_state_t sprite_state;
	nes_dma_pkg::page_t         page_reg;     // Source page high byte
	logic [7:0]                 index;        // Byte within the page
	logic [8:0]                 index_next;   // Bit 8 marks the end of the page
	nes_dma_pkg::data_t         data_latch;   // Byte between read and write

	assign index_next = {1'b0, index} + 9'd1;

	assign sprite_busy     = (sprite_state != nes_dma_pkg::sprite_idle);
	assign sprite_owns_bus = (sprite_state == nes_dma_pkg::sprite_transfer) && !dmc_ack;
	assign sprite_addr     = odd_cycle ? nes_dma_pkg::OAM_DATA_REG : {page_reg, index};
	assign sprite_data     = data_latch;

	always_ff @(posedge clk) begin
		if (reset) begin
			sprite_state <= nes_dma_pkg::sprite_idle;
			index        <= '0;
		end else if (cpu_ce) begin
			if (sprite_start) begin
				sprite_state <= nes_dma_pkg::sprite_align;
				index        <= '0;
			end else begin
				case (sprite_state)
					nes_dma_pkg::sprite_align: begin
						// Start so that the first transfer cycle is even
						if (odd_cycle && cpu_reading)
							sprite_state <= nes_dma_pkg::sprite_transfer;
					end
					nes_dma_pkg::sprite_transfer: begin
						if (!odd_cycle && dmc_ack) begin
							sprite_state <= nes_dma_pkg::sprite_align;  // Same index read again later
						end else if (odd_cycle) begin
							index <= index_next[7:0];
							if (index_next[8])
								sprite_state <= nes_dma_pkg::sprite_idle;  // Byte 255 written
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Latch the byte read in an even transfer cycle
	always_ff @(posedge clk) begin
		if (cpu_ce && sprite_owns_bus && !odd_cycle)
			data_latch <= rdata;
	end

	always_ff @(posedge clk) begin
		if (cpu_ce && sprite_start)
			page_reg <= sprite_page;
	end

endmodule

// ==== tests/nes_dma_chk.sv ====
// --------------------
// Bus ownership and phase rules, bound into dma_bus_mux
// Sampled as cpu_ce rises, mux inputs hold for the whole CPU cycle
// assert_failures counts the failed checks
// --------------------
`timescale 1ns/100ps

module nes_dma_chk (
	input logic                  cpu_ce,
	input logic                  odd_cycle,
	input logic                  dmc_ack,
	input logic                  dmc_req,
	input logic                  sprite_owns_bus,
	input logic                  pause_cpu,
	input nes_dma_pkg::cpu_bus_t cpu_bus,
	input nes_dma_pkg::mem_bus_t mem_bus
);

	int assert_failures = 0;

	// Sprite data only goes out on the odd phase, right after its own read
	dma_write_odd: assert property (@(posedge cpu_ce)
		(sprite_owns_bus && mem_bus.wr)
			|-> odd_cycle && $past(sprite_owns_bus && mem_bus.rd))
		else begin
			assert_failures++;
			$error("DMA write not on the odd cycle after a DMA read");
		end

	// Ack lands on the even cycle two CPU cycles after arming
	dmc_ack_even: assert property (@(posedge cpu_ce)
		dmc_ack |-> !odd_cycle && $past(dmc_req && cpu_bus.rnw && !odd_cycle, 2))
		else begin
			assert_failures++;
			$error("dmc_ack not two CPU cycles after an even read with a request");
		end

	// Any bus cycle that is not the CPU's own needs the CPU held
	dma_owner_paused: assert property (@(posedge cpu_ce)
		(mem_bus != {cpu_bus, !cpu_bus.rnw}) |-> pause_cpu)
		else begin
			assert_failures++;
			$error("DMA drives the bus while the CPU runs");
		end

endmodule

bind dma_bus_mux nes_dma_chk u_chk (
	.cpu_ce          (cpu_ce),
	.odd_cycle       (odd_cycle),
	.dmc_ack         (dmc_ack),
	.dmc_req         (dmc_req),
	.sprite_owns_bus (sprite_owns_bus),
	.pause_cpu       (pause_cpu),
	.cpu_bus         (cpu_bus),
	.mem_bus         (mem_bus)
);

// ==== tests/nes_dma_tb.sv ====
// --------------------
// Testbench for nes_dma_top, LCG stimulus with seed 32'ha30e
// Memory is a hash of the address and answers within the same clk
// Inputs change on the rising edge after cpu_ce, outputs are read mid-cycle
// --------------------
`timescale 1ns/100ps

module nes_dma_tb;

	localparam int CPU_DIVIDE = nes_dma_pkg::CPU_DIVIDE_NTSC;
	localparam int COPY_LIMIT = 1500;   // CPU cycles for one copy with steals

	logic                   clk;
	logic                   reset;
	nes_dma_pkg::cpu_bus_t  cpu_bus;
	nes_dma_pkg::data_t     rdata;
	logic                   dmc_req;
	nes_dma_pkg::cpu_addr_t dmc_addr;
	nes_dma_pkg::mem_bus_t  mem_bus;
	logic                   dmc_ack;
	logic                   pause_cpu;
	logic                   cpu_ce;
	logic                   odd_cycle;

	logic [31:0] rng_state = 32'ha30e;
	int error_count = 0;
	int start_errors = 0;   // Error total when the running test began
	int tests_passed = 0;
	int tests_failed = 0;

	tb_clock clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	nes_dma_top #(.CPU_DIVIDE(CPU_DIVIDE)) UUT (
		.clk(clk), .reset(reset), .cpu_bus(cpu_bus), .rdata(rdata),
		.dmc_req(dmc_req), .dmc_addr(dmc_addr), .mem_bus(mem_bus), .dmc_ack(dmc_ack),
		.pause_cpu(pause_cpu), .cpu_ce(cpu_ce), .odd_cycle(odd_cycle)
	);

	assign rdata = mem_hash(mem_bus.addr);   // Memory model

	// Odd multiplier keeps the 256 bytes of a page distinct
	function automatic nes_dma_pkg::data_t mem_hash(input nes_dma_pkg::cpu_addr_t addr);
		return addr[7:0] * 8'd37 + addr[15:8] * 8'd11 + 8'h5a;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Random CPU cycle, never a write to the sprite trigger
	function automatic nes_dma_pkg::cpu_bus_t random_cpu_bus(input logic reads_only);
		nes_dma_pkg::cpu_bus_t b;
		logic [31:0]           r;
		r = next_random();
		b.addr  = r[30:15];
		b.wdata = r[14:7];
		b.rnw   = reads_only || r[31];
		if (b.addr == nes_dma_pkg::SPRITE_DMA_REG)
			b.addr = 16'h4015;
		return b;
	endfunction

	function automatic int total_errors();
		return error_count + UUT.u_mux.u_chk.assert_failures;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("CHECK FAILED %s got %h expected %h at %0t", name, got, expected, $time);
		error_count++;
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s at %0t", what, $time);
		error_count++;
	endtask

	task automatic abort_run(input string why);
		$display("TIMEOUT %s at %0t", why, $time);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Returns on the falling edge inside the next cpu_ce
	task automatic wait_ce();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (cpu_ce !== 1'b1 && n < 2 * CPU_DIVIDE);
		if (cpu_ce !== 1'b1)
			abort_run("no cpu_ce pulse");
	endtask

	task automatic end_test(input string name);
		if (total_errors() == start_errors) begin
			$display("Test %s: passed", name);
			tests_passed++;
		end else begin
			$display("Test %s: failed, %0d errors", name, total_errors() - start_errors);
			tests_failed++;
		end
		start_errors = total_errors();
	endtask

	task automatic check_reset_state();
		int n;
		if (pause_cpu !== 1'b0)
			report_mismatch("pause_cpu", pause_cpu, 0);
		if (dmc_ack !== 1'b0)
			report_mismatch("dmc_ack", dmc_ack, 0);
		if (odd_cycle !== 1'b0)
			report_mismatch("odd_cycle", odd_cycle, 0);
		wait_ce();
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (cpu_ce !== 1'b1 && n < 2 * CPU_DIVIDE);
		if (n != CPU_DIVIDE)
			report_mismatch("cpu_ce period", n, CPU_DIVIDE);
		if (odd_cycle !== 1'b1)
			report_mismatch("odd_cycle", odd_cycle, 1);   // Second CPU cycle is odd
	endtask

	task automatic check_pass_through(input int cycles);
		nes_dma_pkg::cpu_bus_t b;
		repeat (cycles) begin
			b = random_cpu_bus(1'b0);
			@(posedge clk);
			cpu_bus <= b;
			wait_ce();
			if (mem_bus !== {b, !b.rnw})   // rd follows rnw, wr its inverse
				report_mismatch("mem_bus", mem_bus, {b, !b.rnw});
			if (pause_cpu !== 1'b0)
				report_mismatch("pause_cpu", pause_cpu, 0);
		end
	endtask

	// Lone sample fetches, ack expected two CPU cycles after the arming even cycle
	task automatic run_sample_fetches(input int count);
		int   n;
		int   armed_at;
		logic expect_ack;
		repeat (count) begin
			@(posedge clk);
			cpu_bus  <= random_cpu_bus(1'b1);
			dmc_req  <= 1'b1;
			dmc_addr <= 16'hc000 | 16'(next_random() >> 16);
			armed_at = -1;
			n = 0;
			do begin
				wait_ce();
				n++;
				expect_ack = (armed_at > 0) && (n == armed_at + 2);
				if (armed_at < 0 && odd_cycle === 1'b0)
					armed_at = n;
				if (dmc_ack !== expect_ack)
					report_mismatch("dmc_ack", dmc_ack, expect_ack);
				if (pause_cpu !== 1'b1)
					report_mismatch("pause_cpu", pause_cpu, 1);
			end while (dmc_ack !== 1'b1 && n < 6);
			if (dmc_ack !== 1'b1)
				abort_run("no dmc_ack for a sample request");
			if ({mem_bus.addr, mem_bus.rd, mem_bus.wr} !== {dmc_addr, 2'b10})
				report_mismatch("mem_bus fetch", {mem_bus.addr, mem_bus.rd, mem_bus.wr},
					{dmc_addr, 2'b10});
			@(posedge clk);
			dmc_req <= 1'b0;
			n = next_random() % 4;
			repeat (n + 1) wait_ce();   // Vary the phase of the next request
		end
	endtask

	// One page copy, optionally with random sample requests stealing slots
	task automatic run_sprite_copy(input bit with_dmc);
		nes_dma_pkg::page_t    page;
		nes_dma_pkg::cpu_bus_t b;
		int                    writes;
		int                    cycles;
		int                    last_write;   // CPU cycle of the latest sprite write
		int                    requests;
		int                    acks;
		int                    delay;
		logic                  drop;
		page = 8'(next_random() >> 24);
		writes = 0;
		cycles = 0;
		last_write = 0;
		requests = 0;
		acks = 0;
		delay = next_random() % 16;
		@(posedge clk);
		cpu_bus <= {nes_dma_pkg::SPRITE_DMA_REG, page, 1'b0};   // Page write to the trigger
		wait_ce();
		if (pause_cpu !== 1'b0)
			report_mismatch("pause_cpu", pause_cpu, 0);
		b = random_cpu_bus(1'b1);
		@(posedge clk);
		cpu_bus <= b;   // CPU stalls on a read
		wait_ce();
		if (pause_cpu !== 1'b1)
			report_mismatch("pause_cpu", pause_cpu, 1);
		while (pause_cpu === 1'b1 && cycles < COPY_LIMIT) begin
			drop = 1'b0;
			if (dmc_ack === 1'b1) begin
				if (dmc_req !== 1'b1)
					report_error("dmc_ack without a pending sample request");
				if ({mem_bus.addr, mem_bus.rd, mem_bus.wr} !== {dmc_addr, 2'b10})
					report_mismatch("mem_bus fetch", {mem_bus.addr, mem_bus.rd, mem_bus.wr},
						{dmc_addr, 2'b10});
				acks++;
				drop = 1'b1;
			end
			if (mem_bus.wr === 1'b1) begin
				if (mem_bus.addr !== nes_dma_pkg::OAM_DATA_REG || writes > 255)
					report_error("write outside the 256 sprite bytes");
				else if (mem_bus.wdata !== mem_hash({page, writes[7:0]}))
					report_mismatch("mem_bus.wdata", mem_bus.wdata, mem_hash({page, writes[7:0]}));
				writes++;
				last_write = cycles;
			end
			@(posedge clk);
			if (drop) begin
				dmc_req <= 1'b0;
			end else if (with_dmc && dmc_req !== 1'b1 && writes < 240) begin
				if (delay == 0) begin
					dmc_req  <= 1'b1;
					dmc_addr <= 16'hc000 | 16'(next_random() >> 16);
					requests++;
					delay = next_random() % 32;
				end else begin
					delay--;
				end
			end
			wait_ce();
			cycles++;
		end
		if (pause_cpu !== 1'b0)
			abort_run("sprite copy did not end");
		if (writes != 256)
			report_mismatch("sprite write count", writes, 256);
		else if (cycles != last_write + 1)
			report_error("pause_cpu did not fall right after the last sprite write");
		if (acks != requests)
			report_mismatch("dmc_ack count", acks, requests);
		if (mem_bus !== {b, !b.rnw})   // CPU owns the bus again
			report_mismatch("mem_bus", mem_bus, {b, !b.rnw});
	endtask

	initial begin
		int n;
		cpu_bus  = {16'h8000, 8'h00, 1'b1};   // Idle read
		dmc_req  = 1'b0;
		dmc_addr = '0;
		n = 0;
		while (reset !== 1'b0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (reset !== 1'b0)
			abort_run("reset was not released");
		check_reset_state();
		end_test("1 reset and clock enable");
		check_pass_through(64);
		end_test("2 CPU bus pass-through");
		run_sprite_copy(1'b0);
		end_test("3 sprite copy and pause");
		run_sample_fetches(10);
		end_test("4 sample fetch");
		repeat (3) run_sprite_copy(1'b1);
		end_test("5 sprite copy with sample fetches");
		$display("Tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, total_errors());
		if (total_errors() == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tests/tb_clock.sv ====
// --------------------
// 10 ns clock, reset held for RESET_CYCLES rising edges
// --------------------
`timescale 1ns/100ps

module tb_clock #(
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;           // Released on a rising edge
	end

endmodule
